//--- hdl/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // one core's slice of the hypervector
    typedef logic [31:0] hv_word_t;

    // symbol index into the item tables
    typedef logic [6:0] sym_t;

    // entries per core item table
    localparam int ITEM_DEPTH = 128;

    // item rule
    // entry i of core k = ITEM_SEED + k * CORE_STRIDE + i * ITEM_STEP (mod 2**32)
    localparam hv_word_t ITEM_SEED   = 32'd33215360;
    localparam hv_word_t ITEM_STEP   = 32'd18360;
    // 2**20 + 7
    localparam hv_word_t CORE_STRIDE = 32'd1048583;

    // edges from a sampled symbol strobe to the accumulator update,
    // counting the sequencer register
    localparam int EXEC_LAT = 4;

endpackage

`default_nettype wire

//--- hdl/core_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// broadcast strobes from the sequencer to every core
interface core_ctrl_if;
    import hdc_pkg::*;

    // clear accumulators and position counters
    logic init;
    // symbol strobe and its index
    logic exec;
    sym_t sym;
    // copy acc_left into the output register
    logic snap;
    // move the output chain one core toward the top
    logic shift;

    modport ctrl (
        output init, exec, sym, snap, shift
    );

    modport core (
        input init, exec, sym, snap, shift
    );

endinterface

`default_nettype wire

//--- hdl/item_memory.sv
`timescale 1ns/1ps
`default_nettype none

module item_memory #(
    parameter int CORE_INDEX = 0
) (
    input  wire               clk,
    input  wire               rd_en,
    input  wire hdc_pkg::sym_t addr,
    output hdc_pkg::hv_word_t  item
);
    import hdc_pkg::*;

    hv_word_t rom [ITEM_DEPTH];
    hv_word_t item_q;

    // entry value for this core
    function automatic hv_word_t item_value(input int unsigned idx);
        hv_word_t core_base;
        hv_word_t offset;
        core_base = ITEM_SEED + hv_word_t'(CORE_INDEX) * CORE_STRIDE;
        offset    = hv_word_t'(idx) * ITEM_STEP;
        return core_base + offset;
    endfunction

    // table is fixed at elaboration
    initial begin
        for (int unsigned i = 0; i < ITEM_DEPTH; i++) begin
            rom[i] = item_value(i);
        end
    end

    // registered read, maps onto block ROM
    always_ff @(posedge clk) begin
        if (rd_en) begin
            item_q <= rom[addr];
        end
    end

    assign item = item_q;

endmodule

`default_nettype wire

//--- hdl/bind_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module bind_accumulator (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  init,
    input  wire                  step,
    input  wire hdc_pkg::hv_word_t item,
    output hdc_pkg::hv_word_t     acc
);
    import hdc_pkg::*;

    localparam int WORD_W = $bits(hv_word_t);
    localparam int POS_W  = $clog2(WORD_W);

    // permutation position, counts symbols since the last clear
    logic [POS_W-1:0] pos;
    hv_word_t         acc_q;
    hv_word_t         item_rot;

    // rotate right by the position
    function automatic hv_word_t rotate_right(
        input hv_word_t         word,
        input logic [POS_W-1:0] amount
    );
        logic [2*WORD_W-1:0] doubled;
        doubled = {word, word} >> amount;
        return doubled[WORD_W-1:0];
    endfunction

    assign item_rot = rotate_right(item, pos);

    // init wins over a step landing on the same edge
    always_ff @(posedge clk) begin
        if (rst || init) begin
            pos   <= '0;
            acc_q <= '0;
        end else if (step) begin
            acc_q <= acc_q ^ item_rot;
            // wraps at the word width
            pos   <= pos + 1'b1;
        end
    end

    assign acc = acc_q;

    // a clear is never overtaken by a symbol in the same cycle
    a_init_priority: assert property (
        @(posedge clk) disable iff (rst)
        init |=> (acc_q == '0 && pos == '0)
    );

endmodule

`default_nettype wire

//--- hdl/hdc_core.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_core #(
    parameter int CORE_INDEX = 0
) (
    input  wire                  clk,
    input  wire                  rst,
    core_ctrl_if.core            ctrl,
    input  wire hdc_pkg::hv_word_t chain_in,
    output hdc_pkg::hv_word_t     chain_out
);
    import hdc_pkg::*;

    // strobe delay from the interface to the accumulator stage
    // sequencer register, rom read and item register make up the rest
    localparam int DLY = EXEC_LAT - 2;

    logic [DLY-1:0] exec_dly;
    logic [DLY-1:0] init_dly;
    hv_word_t       item_rd;
    hv_word_t       item_q;
    hv_word_t       acc_left;
    hv_word_t       acc_right;

    item_memory #(
        .CORE_INDEX (CORE_INDEX)
    ) u_items (
        .clk   (clk),
        .rd_en (ctrl.exec),
        .addr  (ctrl.sym),
        .item  (item_rd)
    );

    // exec_dly[0] marks a valid rom word
    // the last stage steps the accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_dly <= '0;
            init_dly <= '0;
        end else begin
            exec_dly <= {exec_dly[DLY-2:0], ctrl.exec};
            init_dly <= {init_dly[DLY-2:0], ctrl.init};
        end
    end

    // breaks the path from rom to the rotate and xor
    always_ff @(posedge clk) begin
        if (exec_dly[0]) begin
            item_q <= item_rd;
        end
    end

    bind_accumulator u_bind (
        .clk  (clk),
        .rst  (rst),
        .init (init_dly[DLY-1]),
        .step (exec_dly[DLY-1]),
        .item (item_q),
        .acc  (acc_left)
    );

    // snapshot, then pass words toward core 0
    always_ff @(posedge clk) begin
        if (ctrl.snap) begin
            acc_right <= acc_left;
        end else if (ctrl.shift) begin
            acc_right <= chain_in;
        end
    end

    assign chain_out = acc_right;

    a_snap_not_shift: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.snap && ctrl.shift)
    );

endmodule

`default_nettype wire

//--- hdl/encode_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module encode_sequencer #(
    parameter int NUM_CORES = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               clear,
    input  wire               sym_valid,
    input  wire hdc_pkg::sym_t sym,
    input  wire               read_req,
    core_ctrl_if.ctrl         ctrl,
    output logic              hv_valid,
    output logic              busy
);
    import hdc_pkg::*;

    localparam int CNT_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(NUM_CORES - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DRAIN = 2'd1;
    localparam logic [1:0] ST_SNAP  = 2'd2;
    localparam logic [1:0] ST_SHIFT = 2'd3;

    logic [1:0]          state;
    logic [CNT_W-1:0]    word_cnt;
    logic [EXEC_LAT-1:0] in_flight;
    logic                drained;
    logic                snap_q;
    logic                shift_q;

    // broadcast strobes, one edge behind the inputs
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.init <= 1'b0;
            ctrl.exec <= 1'b0;
            in_flight <= '0;
        end else begin
            ctrl.init <= clear;
            ctrl.exec <= sym_valid;
            in_flight <= {in_flight[EXEC_LAT-2:0], sym_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (sym_valid) begin
            ctrl.sym <= sym;
        end
    end

    // no symbol left between the inputs and any accumulator
    assign drained = (in_flight == '0);

    // readout FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            snap_q   <= 1'b0;
            shift_q  <= 1'b0;
            busy     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (read_req) begin
                        busy  <= 1'b1;
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (drained) begin
                        snap_q <= 1'b1;
                        state  <= ST_SNAP;
                    end
                end
                ST_SNAP: begin
                    snap_q   <= 1'b0;
                    shift_q  <= 1'b1;
                    word_cnt <= '0;
                    state    <= ST_SHIFT;
                end
                default: begin
                    if (word_cnt == LAST_WORD) begin
                        shift_q <= 1'b0;
                        busy    <= 1'b0;
                        state   <= ST_IDLE;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign ctrl.snap  = snap_q;
    assign ctrl.shift = shift_q;
    // one word per shift cycle, core 0 first
    assign hv_valid   = shift_q;

    a_snap_then_shift: assert property (
        @(posedge clk) disable iff (rst)
        snap_q |-> !shift_q ##1 shift_q
    );

    a_valid_in_busy: assert property (
        @(posedge clk) disable iff (rst)
        hv_valid |-> busy
    );

endmodule

`default_nettype wire

//--- hdl/hdc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_encoder #(
    parameter int NUM_CORES = 8
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               clear,
    input  wire               sym_valid,
    input  wire hdc_pkg::sym_t sym,
    input  wire               read_req,
    output hdc_pkg::hv_word_t  hv_out,
    output logic              hv_valid,
    output logic              busy
);
    import hdc_pkg::*;

    // the symbol has to reach every item entry
    if (ITEM_DEPTH != (1 << $bits(sym_t))) begin : g_depth_check
        $error("sym_t width does not match ITEM_DEPTH");
    end

    // chain[k] is core k's output word, chain[NUM_CORES] feeds the last core
    hv_word_t chain [0:NUM_CORES];

    core_ctrl_if ctrl ();

    encode_sequencer #(
        .NUM_CORES (NUM_CORES)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .sym_valid (sym_valid),
        .sym       (sym),
        .read_req  (read_req),
        .ctrl      (ctrl.ctrl),
        .hv_valid  (hv_valid),
        .busy      (busy)
    );

    for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
        hdc_core #(
            .CORE_INDEX (k)
        ) u_core (
            .clk       (clk),
            .rst       (rst),
            .ctrl      (ctrl.core),
            .chain_in  (chain[k+1]),
            .chain_out (chain[k])
        );
    end

    // zeros shift in behind the last core
    assign chain[NUM_CORES] = '0;

    assign hv_out = chain[0];

endmodule

`default_nettype wire

//--- sim/tb_hdc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_encoder;

    localparam int NUM_CORES  = 8;
    // item rule, entry s of core k = SEED + k * STRIDE + s * STEP
    localparam logic [31:0] SEED   = 32'd33215360;
    localparam logic [31:0] STEP   = 32'd18360;
    localparam logic [31:0] STRIDE = 32'd1048583;
    localparam int WAIT_LIMIT = 64;

    logic        clk;
    logic        rst;
    logic        clear;
    logic        sym_valid;
    logic [6:0]  sym;
    logic        read_req;
    logic [31:0] hv_out;
    logic        hv_valid;
    logic        busy;

    logic [31:0] lfsr_state;
    // reference accumulators, one per core, and the shared position
    logic [31:0] model_acc [NUM_CORES];
    int          model_pos;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;

    hdc_encoder #(
        .NUM_CORES (NUM_CORES)
    ) u_hdc_encoder (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .sym_valid (sym_valid),
        .sym       (sym),
        .read_req  (read_req),
        .hv_out    (hv_out),
        .hv_valid  (hv_valid),
        .busy      (busy)
    );

    always #10 clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out_bit;
    endfunction

    function automatic logic [6:0] rand_sym();
        logic [6:0] s;
        for (int b = 0; b < 7; b++) begin
            s[b] = lfsr_next_bit();
        end
        return s;
    endfunction

    function automatic logic [31:0] item_word(input int k, input logic [6:0] s);
        logic [31:0] core_part;
        logic [31:0] sym_part;
        core_part = STRIDE * 32'(k);
        sym_part  = STEP * {25'd0, s};
        return SEED + core_part + sym_part;
    endfunction

    function automatic logic [31:0] rotr(input logic [31:0] w, input int amount);
        if (amount == 0) begin
            return w;
        end
        return (w >> amount) | (w << (32 - amount));
    endfunction

    function automatic void clear_model();
        for (int k = 0; k < NUM_CORES; k++) begin
            model_acc[k] = '0;
        end
        model_pos = 0;
    endfunction

    function automatic void bind_model(input logic [6:0] s);
        for (int k = 0; k < NUM_CORES; k++) begin
            model_acc[k] = model_acc[k] ^ rotr(item_word(k, s), model_pos);
        end
        model_pos = (model_pos + 1) % 32;
    endfunction

    // all driving tasks start and end just after a falling edge
    task automatic pulse_clear();
        clear = 1'b1;
        clear_model();
        @(negedge clk);
        clear = 1'b0;
    endtask

    task automatic drive_symbol(input logic [6:0] s);
        sym_valid = 1'b1;
        sym = s;
        bind_model(s);
        @(negedge clk);
    endtask

    // back to back, one symbol per cycle
    task automatic send_random(input int n);
        for (int i = 0; i < n; i++) begin
            drive_symbol(rand_sym());
        end
        sym_valid = 1'b0;
    endtask

    task automatic readout(input int n_traffic, input bit second_req);
        logic [31:0] expected [NUM_CORES];
        int waited;
        int extra;
        for (int k = 0; k < NUM_CORES; k++) begin
            expected[k] = model_acc[k];
        end
        read_req = 1'b1;
        @(negedge clk);
        read_req = 1'b0;
        if (busy !== 1'b1) begin
            $display("CHECK FAILED at %0t ns: busy expected 1 got %b", $time, busy);
            test_errors++;
        end
        waited = 0;
        while (!hv_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!hv_valid) begin
            $display("[%0t] timeout, no hv_valid within %0d cycles of read_req",
                     $time, WAIT_LIMIT);
            test_errors++;
            return;
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            if (!hv_valid) begin
                $display("[%0t] hv_valid dropped after %0d of %0d words", $time, k, NUM_CORES);
                test_errors++;
                break;
            end
            if (hv_out !== expected[k]) begin
                $display("CHECK FAILED at %0t ns: hv_out[%0d] expected %08h got %08h",
                         $time, k, expected[k], hv_out);
                test_errors++;
            end
            // new symbols must only reach acc_left
            sym_valid = (k < n_traffic);
            if (k < n_traffic) begin
                sym = rand_sym();
                bind_model(sym);
            end
            read_req = second_req && (k == 2);
            @(negedge clk);
        end
        sym_valid = 1'b0;
        read_req  = 1'b0;
        // a second readout would show up as more hv_valid cycles
        extra = 0;
        waited = 0;
        while (busy && waited < WAIT_LIMIT) begin
            if (hv_valid) begin
                extra++;
            end
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("[%0t] timeout, busy still high %0d cycles after the last word",
                     $time, WAIT_LIMIT);
            test_errors++;
        end
        repeat (12) begin
            if (hv_valid) begin
                extra++;
            end
            @(negedge clk);
        end
        if (extra != 0) begin
            $display("[%0t] hv_valid came back for %0d more cycles after the readout",
                     $time, extra);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("[%0t] %s passed", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s failed with %0d errors", $time, name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_after_reset();
        readout(0, 1'b0);
        finish_test("readout after reset");
    endtask

    task automatic test_single_symbol();
        pulse_clear();
        drive_symbol(7'd93);
        sym_valid = 1'b0;
        readout(0, 1'b0);
        finish_test("single symbol");
    endtask

    // wraps the position counter past 32
    task automatic test_random_stream();
        pulse_clear();
        send_random(40);
        readout(0, 1'b0);
        finish_test("random stream");
    endtask

    task automatic test_clear();
        pulse_clear();
        send_random(5);
        pulse_clear();
        send_random(2);
        readout(0, 1'b0);
        finish_test("clear between symbols");
    endtask

    task automatic test_readout_protection();
        pulse_clear();
        send_random(3);
        // read_req one cycle after the last sym_valid
        readout(4, 1'b1);
        readout(0, 1'b0);
        finish_test("readout protection");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        clear        = 1'b0;
        sym_valid    = 1'b0;
        sym          = '0;
        read_req     = 1'b0;
        lfsr_state   = 32'hd04a0bc5;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_after_reset();
        test_single_symbol();
        test_random_stream();
        test_clear();
        test_readout_protection();

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/hdc_pkg.sv
hdl/core_ctrl_if.sv
hdl/item_memory.sv
hdl/bind_accumulator.sv
hdl/hdc_core.sv
hdl/encode_sequencer.sv
hdl/hdc_encoder.sv
sim/tb_hdc_encoder.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_hdc_encoder \
    -f all.f -o tb_hdc_encoder > build.log 2>&1 &&
./obj_dir/tb_hdc_encoder > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
